// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    // data and pc width
    localparam int XLEN = 32;

    // register index width, x0 always reads zero
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS = 1 << REG_IDX_W;

    // fetch buffer entries
    // sender starts out holding this many credits
    localparam int FETCH_DEPTH = 4;
    localparam int PTR_W = $clog2(FETCH_DEPTH);
    // occupancy counter must reach FETCH_DEPTH
    localparam int CREDIT_W = 3;

    // iterative multiply
    localparam int MUL_STEPS = 4;
    // bits of operand b consumed per step
    localparam int MUL_SLICE_W = XLEN / MUL_STEPS;
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);

    // immediate field
    localparam int IMM_W = 13;
    // lui puts imm in the top bits of the word
    localparam int LUI_SHIFT = XLEN - IMM_W;

    // opcodes
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        ADDI = 4'd7,
        LUI  = 4'd8,
        MUL  = 4'd9
    } op_e;

    // instruction word, opcode in the top nibble
    typedef struct packed {
        op_e                  opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [IMM_W-1:0]     imm;
    } inst_t;

    // packet from the sender into the fetch buffer
    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_t           inst;
    } fetch_pkt_t;

    // decode register contents
    // operands are already resolved
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        op_e                  opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      opa;
        logic [XLEN-1:0]      opb;
    } id_pkt_t;

    // one bypass source
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] idx;
        logic [XLEN-1:0]      data;
    } fwd_t;

    // committed instruction record, also the ex result
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic                 we;
        logic [REG_IDX_W-1:0] rnum;
        logic [XLEN-1:0]      wdata;
    } dbg_t;

endpackage

`default_nettype wire

// File: verilog/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       push_i,
    input  fetch_pkt_t push_pkt_i,
    input  logic       pop_i,
    output fetch_pkt_t head_pkt_o,
    output logic       not_empty_o,
    output logic       credit_o
);

    // packet storage
    fetch_pkt_t mem_q [FETCH_DEPTH];

    // circular pointers, wrap at power of two depth
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    // entries held
    logic [CREDIT_W-1:0] count_q;

    // write side
    // credit flow keeps push away from a full buffer
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_pkt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together leave count unchanged
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // one credit back per pop, a cycle later
            credit_o <= pop_i;
        end
    end

    // head entry visible to decode
    assign head_pkt_o  = mem_q[rd_ptr_q];
    assign not_empty_o = (count_q != '0);

endmodule

`default_nettype wire

// File: verilog/pipeline_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_ctrl (
    input  logic clk,
    input  logic reset_i,
    // buffer has a packet
    input  logic not_empty_i,
    // execute result ready this cycle
    input  logic ex_done_i,
    output logic pop_o,
    output logic ex_go_o,
    output logic wb_load_o
);

    // id stage holds an instruction
    logic id_valid_q;
    // id instruction leaves this cycle
    logic id_finish;

    // execute only finishes what decode holds
    assign id_finish = id_valid_q & ex_done_i;

    // advance id when empty or draining
    // a busy multiply keeps ex_done low
    // so pop stays low and the buffer fills
    assign pop_o = not_empty_i & (~id_valid_q | id_finish);

    // execute works on the decode register whenever it is valid
    assign ex_go_o = id_valid_q;

    // result moves into writeback as execute finishes
    assign wb_load_o = id_finish;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid_q <= 1'b0;
        end else begin
            if (pop_o) begin
                // new instruction replaces the finished one
                id_valid_q <= 1'b1;
            end else if (id_finish) begin
                // drained with nothing behind it
                id_valid_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    // id advance
    input  logic                 load_i,
    input  fetch_pkt_t           pkt_i,
    input  fwd_t                 ex_fwd_i,
    input  fwd_t                 wb_fwd_i,
    output logic [REG_IDX_W-1:0] rs1_idx_o,
    output logic [REG_IDX_W-1:0] rs2_idx_o,
    input  logic [XLEN-1:0]      rs1_data_i,
    input  logic [XLEN-1:0]      rs2_data_i,
    output id_pkt_t              id_o
);

    inst_t           inst;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] opb;

    // youngest producer wins
    // ex first, then wb, then the register file
    function automatic logic [XLEN-1:0] bypass_sel(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      rf_data,
        input fwd_t                 ex_fwd,
        input fwd_t                 wb_fwd
    );
        if (ex_fwd.valid && ex_fwd.idx == idx) begin
            return ex_fwd.data;
        end
        if (wb_fwd.valid && wb_fwd.idx == idx) begin
            return wb_fwd.data;
        end
        return rf_data;
    endfunction

    // field split of the head packet
    assign inst      = pkt_i.inst;
    assign rs1_idx_o = inst.rs1;
    assign rs2_idx_o = inst.rs2;

    assign rs1_val = bypass_sel(inst.rs1, rs1_data_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val = bypass_sel(inst.rs2, rs2_data_i, ex_fwd_i, wb_fwd_i);

    // immediate forms replace rs2
    always_comb begin
        case (inst.opcode)
            ADDI:    opb = {{(XLEN-IMM_W){inst.imm[IMM_W-1]}}, inst.imm};
            LUI:     opb = {inst.imm, {LUI_SHIFT{1'b0}}};
            default: opb = rs2_val;
        endcase
    end

    // decode register, holds while execute is busy
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_o <= '0;
        end else if (load_i) begin
            id_o <= '{pc: pkt_i.pc, opcode: inst.opcode, rd: inst.rd, opa: rs1_val, opb: opb};
        end
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    // decode register holds a valid instruction
    input  logic    go_i,
    input  id_pkt_t id_i,
    output logic    done_o,
    output dbg_t    result_o,
    output fwd_t    ex_fwd_o
);

    typedef enum logic {
        IDLE,
        RUN
    } mul_state_e;

    mul_state_e           state_q;
    logic [MUL_CNT_W-1:0] step_q;

    // shift-add operands and running sum
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic [XLEN-1:0] acc_q;

    logic [XLEN-1:0] mul_a;
    logic [XLEN-1:0] mul_b;
    logic [XLEN-1:0] mul_acc;
    logic [XLEN-1:0] mul_sum;
    logic            is_mul;
    logic            mul_last;
    logic [XLEN-1:0] alu_res;
    logic            we;

    assign is_mul = (id_i.opcode == MUL);

    // first step works straight off the decode register
    assign mul_a   = (state_q == IDLE) ? id_i.opa : a_q;
    assign mul_b   = (state_q == IDLE) ? id_i.opb : b_q;
    assign mul_acc = (state_q == IDLE) ? '0 : acc_q;
    // low slice of b times shifted a, wraps at XLEN
    assign mul_sum = mul_acc + mul_a * XLEN'(mul_b[MUL_SLICE_W-1:0]);

    // step MUL_STEPS-1 completes the product
    assign mul_last = (state_q == RUN) && (step_q == MUL_CNT_W'(MUL_STEPS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (go_i && is_mul) begin
                        state_q <= RUN;
                        step_q  <= MUL_CNT_W'(1);
                    end
                end
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (mul_last) begin
                        state_q <= IDLE;
                        step_q  <= '0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // next slice lines up with the next 8 bits of b
    always_ff @(posedge clk) begin
        a_q   <= mul_a << MUL_SLICE_W;
        b_q   <= mul_b >> MUL_SLICE_W;
        acc_q <= mul_sum;
    end

    // single-cycle ops, shifts take the low 5 bits of b
    always_comb begin
        case (id_i.opcode)
            ADD:     alu_res = id_i.opa + id_i.opb;
            SUB:     alu_res = id_i.opa - id_i.opb;
            AND:     alu_res = id_i.opa & id_i.opb;
            OR:      alu_res = id_i.opa | id_i.opb;
            XOR:     alu_res = id_i.opa ^ id_i.opb;
            SLL:     alu_res = id_i.opa << id_i.opb[4:0];
            SRL:     alu_res = id_i.opa >> id_i.opb[4:0];
            ADDI:    alu_res = id_i.opa + id_i.opb;
            // decode already shifted the immediate
            LUI:     alu_res = id_i.opb;
            MUL:     alu_res = mul_sum;
            default: alu_res = '0;
        endcase
    end

    // x0 never written
    assign we     = (id_i.rd != '0);
    assign done_o = go_i & (~is_mul | mul_last);

    assign result_o = '{pc: id_i.pc, we: we, rnum: id_i.rd, wdata: alu_res};
    // forward only a finished result
    assign ex_fwd_o = '{valid: done_o & we, idx: id_i.rd, data: alu_res};

endmodule

`default_nettype wire

// File: verilog/writeback_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_regfile
    import core_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 load_i,
    input  dbg_t                 result_i,
    input  logic [REG_IDX_W-1:0] rs1_idx_i,
    input  logic [REG_IDX_W-1:0] rs2_idx_i,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    output fwd_t                 wb_fwd_o,
    output logic                 dbg_valid_o,
    output dbg_t                 dbg_o
);

    // writeback register
    dbg_t            wb_q;
    logic            wb_valid_q;
    // architectural registers
    logic [XLEN-1:0] rf_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            wb_q <= result_i;
        end
    end

    // register file is written from wb at the end of its cycle
    // all registers come out of reset as zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_valid_q && wb_q.we) begin
            rf_q[wb_q.rnum] <= wb_q.wdata;
        end
    end

    // read ports, x0 reads zero
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : rf_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : rf_q[rs2_idx_i];

    // covers the cycle before the file holds the value
    assign wb_fwd_o = '{valid: wb_valid_q & wb_q.we, idx: wb_q.rnum, data: wb_q.wdata};

    // one trace record per committed instruction
    assign dbg_valid_o = wb_valid_q;
    assign dbg_o       = wb_q;

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    // credited instruction packets
    input  logic       inst_valid_i,
    input  fetch_pkt_t inst_i,
    output logic       credit_o,
    // commit trace
    output logic       dbg_valid_o,
    output dbg_t       dbg_o
);

    // fetch buffer to decode
    fetch_pkt_t           head_pkt;
    logic                 not_empty;
    logic                 pop;

    // control
    logic                 ex_go;
    logic                 ex_done;
    logic                 wb_load;

    // datapath
    id_pkt_t              id_pkt;
    dbg_t                 ex_result;
    fwd_t                 ex_fwd;
    fwd_t                 wb_fwd;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;

    fetch_buffer u_fetch_buffer (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (inst_valid_i),
        .push_pkt_i  (inst_i),
        .pop_i       (pop),
        .head_pkt_o  (head_pkt),
        .not_empty_o (not_empty),
        .credit_o    (credit_o)
    );

    pipeline_ctrl u_pipeline_ctrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .not_empty_i (not_empty),
        .ex_done_i   (ex_done),
        .pop_o       (pop),
        .ex_go_o     (ex_go),
        .wb_load_o   (wb_load)
    );

    // decode loads on every pop
    decode_stage u_decode_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .load_i     (pop),
        .pkt_i      (head_pkt),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb_fwd),
        .rs1_idx_o  (rs1_idx),
        .rs2_idx_o  (rs2_idx),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_o       (id_pkt)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .reset_i  (reset_i),
        .go_i     (ex_go),
        .id_i     (id_pkt),
        .done_o   (ex_done),
        .result_o (ex_result),
        .ex_fwd_o (ex_fwd)
    );

    writeback_regfile u_writeback_regfile (
        .clk         (clk),
        .reset_i     (reset_i),
        .load_i      (wb_load),
        .result_i    (ex_result),
        .rs1_idx_i   (rs1_idx),
        .rs2_idx_i   (rs2_idx),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .wb_fwd_o    (wb_fwd),
        .dbg_valid_o (dbg_valid_o),
        .dbg_o       (dbg_o)
    );

endmodule

`default_nettype wire

// File: test/core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module core_properties
    import core_pkg::*;
(
    input logic                clk,
    input logic                reset_i,
    input logic                push_i,
    input logic                pop_i,
    input logic                credit_o,
    input logic [CREDIT_W-1:0] count_q
);

    // credit flow keeps the sender off a full buffer
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset_i)
        (count_q == CREDIT_W'(FETCH_DEPTH)) |-> !push_i
    ) else $error("push into a full fetch buffer");

    // credit flop cleared by reset
    credit_low_in_reset: assert property (
        @(posedge clk) reset_i |=> !credit_o
    ) else $error("credit_o high after a reset cycle");

    // each credit pulse follows a pop by one cycle
    credit_after_pop: assert property (
        @(posedge clk) disable iff (reset_i)
        credit_o |-> $past(pop_i)
    ) else $error("credit_o without a pop in the previous cycle");

endmodule

bind fetch_buffer core_properties u_core_properties (
    .clk      (clk),
    .reset_i  (reset_i),
    .push_i   (push_i),
    .pop_i    (pop_i),
    .credit_o (credit_o),
    .count_q  (count_q)
);

`default_nettype wire

// File: test/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import core_pkg::*;
();

    // instruction counts per test, also size the watchdog
    localparam int N_ALU = 10;
    localparam int N_CHAIN = 8;
    localparam int N_MUL = 8;
    localparam int N_X0 = 4;
    localparam int N_RAND = 200;
    localparam int N_TOTAL = N_ALU + N_CHAIN + N_MUL + N_X0 + N_RAND;
    localparam int WATCHDOG_CYCLES = 20 * N_TOTAL * (MUL_STEPS + 3);

    logic       clk;
    logic       reset_i;
    logic       inst_valid_i;
    fetch_pkt_t inst_i;
    logic       credit_o;
    logic       dbg_valid_o;
    dbg_t       dbg_o;

    // architectural state as the reference sees it
    logic [XLEN-1:0] model_regs [NUM_REGS];
    // expected trace records in send order
    dbg_t            exp_q [$];
    // opcodes in send order, one per credit that comes back
    op_e             sent_ops [$];
    dbg_t            exp_rec;
    logic [XLEN-1:0] pc_next;
    inst_t           rand_inst;
    op_e             chain_ops [N_CHAIN] = '{ADDI, ADD, SUB, XOR, OR, SLL, ADD, SRL};
    int              sent_cnt;
    int              credits_back;
    // cycles left in which no credit may come back
    int              mul_quiet;
    int              rec_cnt;
    int              errors;
    int              base_errors;
    int              tests_run;
    int              prev_rd;
    int              prev2_rd;
    int              gap;
    int              seed = 32'h7e5;

    core_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .credit_o     (credit_o),
        .dbg_valid_o  (dbg_valid_o),
        .dbg_o        (dbg_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hard stop if the pipeline locks up
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired with %0d trace records still outstanding", exp_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    // returned credits, sampled on the rising edge
    // a multiply holds decode, so its credit is followed by
    // MUL_STEPS-1 edges with no further credit
    always @(posedge clk) begin
        if (!reset_i && credit_o) begin
            assert (mul_quiet == 0) else begin
                $display("credit returned at %0t while a multiply was still running", $time);
                errors++;
            end
            credits_back <= credits_back + 1;
        end
        if (!reset_i && credit_o && sent_ops[credits_back] == MUL) begin
            mul_quiet <= MUL_STEPS - 1;
        end else if (mul_quiet != 0) begin
            mul_quiet <= mul_quiet - 1;
        end
    end

    function automatic inst_t encode(op_e op, int rd, int rs1, int rs2, int imm);
        return '{opcode: op, rd: 5'(rd), rs1: 5'(rs1), rs2: 5'(rs2), imm: 13'(imm)};
    endfunction

    // expected record from the operation rules, updates the model in send order
    function automatic dbg_t expect_result(fetch_pkt_t pkt);
        inst_t           i;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        i = pkt.inst;
        a = model_regs[i.rs1];
        b = model_regs[i.rs2];
        case (i.opcode)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            SLL:     res = a << b[4:0];
            SRL:     res = a >> b[4:0];
            ADDI:    res = a + {{19{i.imm[12]}}, i.imm};
            LUI:     res = {i.imm, 19'b0};
            MUL:     res = a * b;
            default: res = '0;
        endcase
        if (i.rd != '0) begin
            model_regs[i.rd] = res;
        end
        return '{pc: pkt.pc, we: (i.rd != '0), rnum: i.rd, wdata: res};
    endfunction

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // compare every committed record against the queue head
    always @(posedge clk) begin
        if (!reset_i && dbg_valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("trace record at %0t with no instruction outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                check_field("dbg_o.pc", dbg_o.pc, exp_rec.pc);
                check_field("dbg_o.we", 32'(dbg_o.we), 32'(exp_rec.we));
                check_field("dbg_o.rnum", 32'(dbg_o.rnum), 32'(exp_rec.rnum));
                check_field("dbg_o.wdata", dbg_o.wdata, exp_rec.wdata);
                rec_cnt++;
            end
        end
    end

    task automatic check_idle();
        assert (!credit_o && !dbg_valid_o) else begin
            $display("FAILED t=%0t credit_o,dbg_valid_o got %b%b expected 00",
                     $time, credit_o, dbg_valid_o);
            errors++;
        end
    endtask

    task automatic check_credits();
        assert (credits_back == sent_cnt) else begin
            $display("FAILED t=%0t credit_o count got %0d expected %0d",
                     $time, credits_back, sent_cnt);
            errors++;
        end
    endtask

    // called on a falling edge, waits for a credit, one-cycle valid pulse
    task automatic send_inst(input inst_t inst);
        fetch_pkt_t pkt;
        while (FETCH_DEPTH + credits_back - sent_cnt <= 0) @(negedge clk);
        pkt = '{pc: pc_next, inst: inst};
        exp_q.push_back(expect_result(pkt));
        sent_ops.push_back(inst.opcode);
        inst_valid_i = 1'b1;
        inst_i       = pkt;
        sent_cnt++;
        pc_next += 4;
        @(negedge clk);
        inst_valid_i = 1'b0;
    endtask

    task automatic drain_and_report(input string name);
        while (exp_q.size() != 0) @(negedge clk);
        tests_run++;
        $display("test %s done with %0d errors", name, errors - base_errors);
        base_errors = errors;
    endtask

    initial begin
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_next      = 32'h0000_1000;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        // outputs quiet through reset and the idle gap after it
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        reset_i = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        drain_and_report("reset");

        // seed a few registers then the plain alu ops
        send_inst(encode(ADDI, 1, 0, 0, 13'h0765));
        send_inst(encode(LUI, 2, 0, 0, 13'h1abc));
        send_inst(encode(ADDI, 3, 0, 0, -5));
        send_inst(encode(ADD, 4, 1, 2, 0));
        send_inst(encode(SUB, 5, 1, 3, 0));
        send_inst(encode(AND, 6, 2, 3, 0));
        send_inst(encode(OR, 7, 1, 2, 0));
        send_inst(encode(XOR, 8, 2, 3, 0));
        send_inst(encode(SLL, 9, 1, 3, 0));
        send_inst(encode(SRL, 10, 2, 1, 0));
        drain_and_report("alu");

        // each op reads the rd just written, back to back
        // even steps also read the rd from two back, which sits in wb
        prev_rd  = 1;
        prev2_rd = 3;
        for (int k = 0; k < N_CHAIN; k++) begin
            send_inst(encode(chain_ops[k], 11 + k, prev_rd,
                             (k % 2 == 1) ? prev_rd : prev2_rd, 37 + k));
            prev2_rd = prev_rd;
            prev_rd  = 11 + k;
        end
        drain_and_report("chain");

        // multiplies with dependents right behind
        send_inst(encode(ADDI, 20, 0, 0, 13'h00f3));
        send_inst(encode(LUI, 21, 0, 0, 13'h0ab5));
        send_inst(encode(MUL, 22, 20, 21, 0));
        send_inst(encode(MUL, 23, 22, 22, 0));
        send_inst(encode(ADD, 24, 23, 22, 0));
        send_inst(encode(MUL, 25, 24, 3, 0));
        send_inst(encode(SUB, 26, 25, 20, 0));
        send_inst(encode(MUL, 27, 26, 26, 0));
        drain_and_report("mul");
        check_credits();

        // x0 as destination and as source
        send_inst(encode(ADDI, 0, 1, 0, 5));
        send_inst(encode(ADD, 0, 2, 3, 0));
        send_inst(encode(ADD, 28, 0, 1, 0));
        send_inst(encode(OR, 29, 0, 0, 0));
        drain_and_report("x0");

        // random program with random idle gaps
        for (int k = 0; k < N_RAND; k++) begin
            rand_inst        = inst_t'($random(seed));
            rand_inst.opcode = op_e'(4'({$random(seed)} % 10));
            send_inst(rand_inst);
            gap = {$random(seed)} % 4;
            repeat (gap) @(negedge clk);
        end
        drain_and_report("random");

        repeat (4) @(negedge clk);
        check_credits();
        assert (rec_cnt == sent_cnt) else begin
            $display("FAILED t=%0t dbg_valid_o count got %0d expected %0d",
                     $time, rec_cnt, sent_cnt);
            errors++;
        end
        $display("%0d tests, %0d records, %0d sent, %0d errors",
                 tests_run, rec_cnt, sent_cnt, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/core_pkg.sv
verilog/fetch_buffer.sv
verilog/pipeline_ctrl.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_regfile.sv
verilog/core_top.sv
test/core_properties.sv
test/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_core with Verilator, status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_core -f vlog.f || exit 1

sim_out="$(./obj_dir/Vtb_core)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -q "^Simulation finished: PASS$" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
